/* verilog/board_defines.svh */
`ifndef BOARD_DEFINES_SVH
`define BOARD_DEFINES_SVH

`define CLK_MHZ    50                                      // System clock.
`define TM_BIT_KHZ 500                                     // Serial bit rate.

// Clocks per half bit of the TM1638 serial clock.
`define TM_HALF_BIT_CLKS ((`CLK_MHZ * 1000) / (2 * `TM_BIT_KHZ))

`define W_DIGIT 8                                          // Seven-segment digits.
`define W_KEY   8                                          // Panel keys.
`define W_LED   8                                          // Panel LEDs.

`define TM_DATA_BYTES 16                                   // Display RAM bytes.
`define TM_READ_BYTES 4                                    // Key scan bytes.

`endif

/* verilog/board_pkg.sv */
`default_nettype none

`include "board_defines.svh"

package board_pkg;

    typedef logic [7:0]            seg_t;                  // One segment pattern.
    typedef logic [`W_DIGIT - 1:0] digit_t;                // One-hot digit select.
    typedef logic [`W_KEY   - 1:0] key_t;                  // 1 = pressed.
    typedef logic [`W_LED   - 1:0] led_t;
    typedef logic [7:0]            tm_byte_t;              // One serial byte.
    typedef logic [31:0]           count_t;

    localparam tm_byte_t CMD_WRITE_AUTO = 8'h40;           // Write, auto increment.
    localparam tm_byte_t CMD_ADDR0      = 8'hC0;
    localparam tm_byte_t CMD_DISPLAY_ON = 8'h8F;           // Full brightness.
    localparam tm_byte_t CMD_READ_KEYS  = 8'h42;

    // Command groups of one panel frame, in order.
    localparam logic [2:0] PH_WRITE   = 3'd0;
    localparam logic [2:0] PH_ADDR    = 3'd1;
    localparam logic [2:0] PH_DISPLAY = 3'd2;
    localparam logic [2:0] PH_READ    = 3'd3;

    typedef enum logic [2:0]
    {
        IDLE_GAP,
        CMD_SEND,
        DATA_SEND,
        KEY_READ,
        STB_RELEASE
    } tm_state_e;

    typedef struct packed
    {
        logic [2:0] phase;                                 // Command group.
        logic [4:0] index;                                 // 0 is the command byte.
    } tm_step_t;

endpackage

`default_nettype wire

/* verilog/tm_bit_timer.sv */
`default_nettype none

`include "board_defines.svh"

module tm_bit_timer
(
    input  logic clk,
    input  logic rst,
    input  logic run,
    output logic half_tick,
    output logic sclk_level
);

    localparam int HALF_CLKS = `TM_HALF_BIT_CLKS;
    localparam int CNT_W     = $clog2(HALF_CLKS + 1);

    logic [CNT_W - 1:0] cnt;

    assign half_tick = run && (cnt == CNT_W'(HALF_CLKS - 1));

    always_ff @(posedge clk)
    begin
        if (rst || !run)
        begin
            cnt        <= '0;
            sclk_level <= 1'b1;                            // Bus clock idles high.
        end
        else if (half_tick)
        begin
            cnt        <= '0;
            sclk_level <= ~sclk_level;
        end
        else
            cnt <= cnt + 1'b1;
    end

endmodule

`default_nettype wire

/* verilog/tm_shift_unit.sv */
`default_nettype none

module tm_shift_unit
(
    input  logic                clk,
    input  logic                rst,
    input  logic                byte_start,
    input  logic                read_mode,
    input  board_pkg::tm_byte_t tx_byte,
    input  logic                half_tick,
    input  logic                sclk_level,
    input  logic                sio_data_in,
    output logic                busy,
    output logic                byte_done,
    output board_pkg::tm_byte_t rx_byte,
    output logic                sio_data_out,
    output logic                sio_data_oe
);

    import board_pkg::*;

    tm_byte_t   shreg;
    logic [2:0] bit_cnt;
    logic       rd_mode;
    logic       fall_tick;
    logic       rise_tick;

    assign fall_tick   = half_tick &&  sclk_level;
    assign rise_tick   = half_tick && !sclk_level;
    assign rx_byte     = shreg;
    assign sio_data_oe = busy && !rd_mode;                 // Released during reads.

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy         <= 1'b0;
            byte_done    <= 1'b0;
            bit_cnt      <= '0;
            rd_mode      <= 1'b0;
            sio_data_out <= 1'b1;
        end
        else
        begin
            byte_done <= 1'b0;

            if (byte_start)
            begin
                busy    <= 1'b1;
                bit_cnt <= '0;
                rd_mode <= read_mode;
            end
            else if (busy)
            begin
                if (fall_tick && !rd_mode)
                    sio_data_out <= shreg [0];              // Next bit while clock is low.

                if (rise_tick)
                begin
                    bit_cnt <= bit_cnt + 1'b1;

                    if (bit_cnt == 3'd7)
                    begin
                        busy      <= 1'b0;
                        byte_done <= 1'b1;
                    end
                end
            end
        end
    end

    // One shift serves both directions, LSB first.
    always_ff @(posedge clk)
    begin
        if (byte_start)
            shreg <= tx_byte;
        else if (busy && rise_tick)
            shreg <= { sio_data_in, shreg [7:1] };
    end

endmodule

`default_nettype wire

/* verilog/tm_frame_builder.sv */
`default_nettype none

`include "board_defines.svh"

module tm_frame_builder
(
    input  logic                clk,
    input  logic                rst,
    input  board_pkg::tm_step_t step,
    input  board_pkg::seg_t     hgfedcba,
    input  board_pkg::digit_t   digit,
    input  board_pkg::led_t     ledr,
    output board_pkg::tm_byte_t tx_byte
);

    import board_pkg::*;

    seg_t       seg_q [`W_DIGIT];
    led_t       led_q;
    logic [3:0] addr;

    assign addr = 4'(step.index - 5'd1);                   // Display RAM address.

    // Catch each digit while the scan selects it.
    always_ff @(posedge clk)
    begin
        for (int k = 0; k < `W_DIGIT; k++)
        begin
            if (digit [k])
                seg_q [k] <= hgfedcba;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            led_q <= '0;
        else
            led_q <= ledr;
    end

    always_comb
    begin
        case (step.phase)
            PH_WRITE   : tx_byte = CMD_WRITE_AUTO;
            PH_DISPLAY : tx_byte = CMD_DISPLAY_ON;
            PH_READ    : tx_byte = CMD_READ_KEYS;
            default    :
                if (step.index == 5'd0)
                    tx_byte = CMD_ADDR0;
                else if (!addr [0])
                    tx_byte = seg_q [addr [3:1]];           // Even address, segments.
                else
                    tx_byte = { 7'b0, led_q [addr [3:1]] }; // Odd address, one LED.
        endcase
    end

endmodule

`default_nettype wire

/* verilog/tm1638_board_controller.sv */
`default_nettype none

`include "board_defines.svh"

module tm1638_board_controller
(
    input  logic              clk,
    input  logic              rst,
    input  board_pkg::seg_t   hgfedcba,
    input  board_pkg::digit_t digit,
    input  board_pkg::led_t   ledr,
    input  logic              sio_data_in,
    output board_pkg::key_t   keys,
    output logic              sio_clk,
    output logic              sio_stb,
    output logic              sio_data_out,
    output logic              sio_data_oe
);

    import board_pkg::*;

    localparam int GAP_CLKS = 2 * `TM_HALF_BIT_CLKS;       // One bit period.
    localparam int GAP_W    = $clog2(GAP_CLKS + 1);

    tm_state_e          state;
    tm_step_t           step;
    logic [GAP_W - 1:0] gap_cnt;
    logic               byte_start;
    logic               byte_done;
    logic               busy;
    logic               half_tick;
    logic               read_mode;
    tm_byte_t           tx_byte;
    tm_byte_t           rx_byte;
    key_t               key_buf;
    key_t               key_next;
    logic [1:0]         rd_idx;

    ////////////////////////////////////////////////////////////////////////////
    // Serial datapath.

    tm_bit_timer i_timer
    (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .run        ( busy       ),
        .half_tick  ( half_tick  ),
        .sclk_level ( sio_clk    )
    );

    tm_shift_unit i_shift
    (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .byte_start   ( byte_start   ),
        .read_mode    ( read_mode    ),
        .tx_byte      ( tx_byte      ),
        .half_tick    ( half_tick    ),
        .sclk_level   ( sio_clk      ),
        .sio_data_in  ( sio_data_in  ),
        .busy         ( busy         ),
        .byte_done    ( byte_done    ),
        .rx_byte      ( rx_byte      ),
        .sio_data_out ( sio_data_out ),
        .sio_data_oe  ( sio_data_oe  )
    );

    tm_frame_builder i_frame
    (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .step     ( step     ),
        .hgfedcba ( hgfedcba ),
        .digit    ( digit    ),
        .ledr     ( ledr     ),
        .tx_byte  ( tx_byte  )
    );

    assign read_mode = (state == KEY_READ);

    ////////////////////////////////////////////////////////////////////////////
    // Key assembly. Bit 0 and bit 4 of each read byte hold two keys.

    assign rd_idx = step.index [1:0] - 2'd1;

    always_comb
    begin
        key_next                  = key_buf;
        key_next [2 * rd_idx]     = rx_byte [0];
        key_next [2 * rd_idx + 1] = rx_byte [4];
    end

    always_ff @(posedge clk)
    begin
        if (state == KEY_READ && byte_done)
            key_buf <= key_next;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Frame sequencer.

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= IDLE_GAP;
            step       <= '0;
            gap_cnt    <= '0;
            byte_start <= 1'b0;
            sio_stb    <= 1'b1;
            keys       <= '0;
        end
        else
        begin
            byte_start <= 1'b0;

            case (state)
                IDLE_GAP:
                    if (gap_cnt == GAP_W'(GAP_CLKS - 1))
                    begin
                        gap_cnt    <= '0;
                        sio_stb    <= 1'b0;                 // Open the group.
                        byte_start <= 1'b1;
                        state      <= CMD_SEND;
                    end
                    else
                        gap_cnt <= gap_cnt + 1'b1;

                CMD_SEND:
                    if (byte_done)
                    begin
                        if (step.phase == PH_ADDR || step.phase == PH_READ)
                        begin
                            step.index <= 5'd1;
                            byte_start <= 1'b1;
                            state      <= (step.phase == PH_READ) ? KEY_READ : DATA_SEND;
                        end
                        else
                            state <= STB_RELEASE;
                    end

                DATA_SEND:
                    if (byte_done)
                    begin
                        if (step.index == 5'(`TM_DATA_BYTES))
                            state <= STB_RELEASE;
                        else
                        begin
                            step.index <= step.index + 1'b1;
                            byte_start <= 1'b1;
                        end
                    end

                KEY_READ:
                    if (byte_done)
                    begin
                        if (step.index == 5'(`TM_READ_BYTES))
                        begin
                            keys  <= key_next;               // Whole scan at once.
                            state <= STB_RELEASE;
                        end
                        else
                        begin
                            step.index <= step.index + 1'b1;
                            byte_start <= 1'b1;
                        end
                    end

                default:                                    // STB_RELEASE.
                begin
                    sio_stb    <= 1'b1;
                    step.index <= '0;
                    step.phase <= (step.phase == PH_READ) ? PH_WRITE : step.phase + 1'b1;
                    state      <= IDLE_GAP;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/lab_top.sv */
`default_nettype none

`include "board_defines.svh"

module lab_top
(
    input  logic              clk,
    input  logic              rst,
    input  board_pkg::key_t   key,
    output board_pkg::led_t   led,
    output board_pkg::seg_t   abcdefgh,
    output board_pkg::digit_t digit
);

    import board_pkg::*;

    key_t       key_prev;
    logic [3:0] rise_cnt;
    count_t     count;
    seg_t       seg_all [`W_DIGIT];

    function automatic seg_t hex_to_seg(input logic [3:0] nib);
        case (nib)                                          // abcdefgh, dot off.
            4'h0: return 8'b1111_1100;
            4'h1: return 8'b0110_0000;
            4'h2: return 8'b1101_1010;
            4'h3: return 8'b1111_0010;
            4'h4: return 8'b0110_0110;
            4'h5: return 8'b1011_0110;
            4'h6: return 8'b1011_1110;
            4'h7: return 8'b1110_0000;
            4'h8: return 8'b1111_1110;
            4'h9: return 8'b1111_0110;
            4'ha: return 8'b1110_1110;
            4'hb: return 8'b0011_1110;
            4'hc: return 8'b1001_1100;
            4'hd: return 8'b0111_1010;
            4'he: return 8'b1001_1110;
            default: return 8'b1000_1110;
        endcase
    endfunction

    assign led = key;

    // Number of keys pressed since the last clock.
    always_comb
    begin
        rise_cnt = '0;
        for (int i = 0; i < `W_KEY; i++)
            rise_cnt = rise_cnt + 4'(key [i] & ~key_prev [i]);
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            key_prev <= '0;
            count    <= '0;
            digit    <= digit_t'(1);
        end
        else
        begin
            key_prev <= key;
            count    <= count + count_t'(rise_cnt);
            digit    <= { digit [`W_DIGIT - 2:0], digit [`W_DIGIT - 1] };
        end
    end

    always_ff @(posedge clk)
    begin
        for (int k = 0; k < `W_DIGIT; k++)
            seg_all [k] <= hex_to_seg(count [4 * k +: 4]);
    end

    always_comb
    begin
        abcdefgh = '0;
        for (int k = 0; k < `W_DIGIT; k++)
            abcdefgh = abcdefgh | (seg_all [k] & {8 {digit [k]}});
    end

endmodule

`default_nettype wire

/* verilog/board_specific_top.sv */
`default_nettype none

module board_specific_top
(
    input  logic clk,
    input  logic rst,
    input  logic sio_data_in,
    output logic sio_clk,
    output logic sio_stb,
    output logic sio_data_out,
    output logic sio_data_oe
);

    import board_pkg::*;

    key_t   tm_key;
    led_t   tm_led;
    digit_t tm_digit;
    seg_t   abcdefgh;
    seg_t   hgfedcba;

    lab_top i_top
    (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .key      ( tm_key   ),
        .led      ( tm_led   ),
        .abcdefgh ( abcdefgh ),
        .digit    ( tm_digit )
    );

    // The panel wants segment a in bit 0.
    for (genvar i = 0; i < $bits(seg_t); i++)
    begin : g_rev
        assign hgfedcba [i] = abcdefgh [$bits(seg_t) - 1 - i];
    end

    tm1638_board_controller i_tm1638
    (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .hgfedcba     ( hgfedcba     ),
        .digit        ( tm_digit     ),
        .ledr         ( tm_led       ),
        .sio_data_in  ( sio_data_in  ),
        .keys         ( tm_key       ),
        .sio_clk      ( sio_clk      ),
        .sio_stb      ( sio_stb      ),
        .sio_data_out ( sio_data_out ),
        .sio_data_oe  ( sio_data_oe  )
    );

endmodule

`default_nettype wire

/* tests/board_chk.sv */
`default_nettype none

`include "board_defines.svh"

module board_chk
(
    input logic clk,
    input logic rst,
    input logic read_mode,
    input logic sio_clk,
    input logic sio_stb,
    input logic sio_data_oe
);

    localparam int GAP_CLKS = 2 * `TM_HALF_BIT_CLKS;      // One bit period.

    int stb_high;                                         // Cycles since the strobe rose.

    always_ff @(posedge clk)
    begin
        if (rst || !sio_stb)
            stb_high <= 0;
        else
            stb_high <= stb_high + 1;
    end

    // Bus clock rests high outside a strobe group.
    a_clk_idle: assert property (@(posedge clk) disable iff (rst) sio_stb |-> sio_clk)
        else $error("sio_clk low while the strobe is high.");

    a_read_released: assert property (@(posedge clk) disable iff (rst)
        read_mode |-> !sio_data_oe)
        else $error("Data line driven during a key read.");

    // Strobe stays high a full bit period after reset and between groups.
    a_stb_gap: assert property (@(posedge clk) disable iff (rst)
        $fell(sio_stb) |-> stb_high >= GAP_CLKS)
        else $error("Strobe fell less than one bit period after reset or a group.");

endmodule

bind tm1638_board_controller board_chk i_chk
(
    .clk         ( clk         ),
    .rst         ( rst         ),
    .read_mode   ( read_mode   ),
    .sio_clk     ( sio_clk     ),
    .sio_stb     ( sio_stb     ),
    .sio_data_oe ( sio_data_oe )
);

`default_nettype wire

/* tests/tb_board_specific_top.sv */
`default_nettype none

`include "board_defines.svh"

module tb_board_specific_top;

    import board_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int HALF_CLKS  = `TM_HALF_BIT_CLKS;
    localparam int GAP_CLKS   = 2 * HALF_CLKS;                 // One bit period.
    localparam int BYTE_CLKS  = 16 * HALF_CLKS + 2;
    localparam int FRAME_CLKS = 4 * (GAP_CLKS + 4) + 24 * BYTE_CLKS;
    localparam int FRAMES     = 30;
    localparam int WATCHDOG   = (40 * FRAME_CLKS + 1000) * CLK_PERIOD;
    localparam logic [31:0] RNG_SEED = 32'hdc533560;

    localparam tm_byte_t EXP_WRITE   = 8'h40;                  // Write, auto increment.
    localparam tm_byte_t EXP_ADDR0   = 8'hC0;
    localparam tm_byte_t EXP_DISPLAY = 8'h8F;
    localparam tm_byte_t EXP_READ    = 8'h42;

    logic clk = 1'b0;
    logic rst;
    logic sio_data_in;
    logic sio_clk;
    logic sio_stb;
    logic sio_data_out;
    logic sio_data_oe;

    tm_byte_t wr_bytes [$];                                    // Bytes of the open group.
    tm_byte_t shift_byte;
    int       bit_cnt;
    int       rd_bits;
    int       group;                                           // 0 to 3 within a frame.
    int       frame;
    int       gap_clks;
    logic     reading;
    logic     started;
    logic     prev_stb;
    logic     prev_sclk;
    key_t     key_vec;                                         // Keys the panel reports.
    key_t     key_last;
    count_t   press_count;
    led_t     led_exp;

    board_specific_top i_dut
    (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .sio_data_in  ( sio_data_in  ),
        .sio_clk      ( sio_clk      ),
        .sio_stb      ( sio_stb      ),
        .sio_data_out ( sio_data_out ),
        .sio_data_oe  ( sio_data_oe  )
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Result checks.

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input tm_byte_t exp, input tm_byte_t act);
        if (act !== exp)
            stop_with_failure($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_seg(input string name, input seg_t exp, input seg_t act);
        if (act !== exp)
            stop_with_failure($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp)
            stop_with_failure($sformatf("Fail %s: expected %0d, actual %0d", name, exp, act));
    endtask

    // Common-cathode codes, segment a in bit 0.
    function automatic seg_t hex_segments(input logic [3:0] nib);
        case (nib)
            4'h0: return 8'h3F;
            4'h1: return 8'h06;
            4'h2: return 8'h5B;
            4'h3: return 8'h4F;
            4'h4: return 8'h66;
            4'h5: return 8'h6D;
            4'h6: return 8'h7D;
            4'h7: return 8'h07;
            4'h8: return 8'h7F;
            4'h9: return 8'h6F;
            4'ha: return 8'h77;
            4'hb: return 8'h7C;
            4'hc: return 8'h39;
            4'hd: return 8'h5E;
            4'he: return 8'h79;
            default: return 8'h71;
        endcase
    endfunction

    // Bit 0 of read byte i is key 2i, bit 4 is key 2i+1.
    function automatic logic read_bit_value(input int pos);
        logic [4:0] p;
        p = 5'(pos);
        if (p [2:0] == 3'd0)
            return key_vec [{p [4:3], 1'b0}];
        else if (p [2:0] == 3'd4)
            return key_vec [{p [4:3], 1'b1}];
        else
            return 1'b0;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // TM1638 device model.

    task automatic expect_idle_bus();
        if (sio_stb !== 1'b1 || sio_clk !== 1'b1 || sio_data_oe !== 1'b0)
            stop_with_failure("Bus was not idle between reset and the first strobe.");
    endtask

    task automatic open_group();
        if (gap_clks < GAP_CLKS)
            stop_with_failure("Strobe went low less than one bit period after it rose.");
        started = 1'b1;
        wr_bytes.delete();
        bit_cnt = 0;
        rd_bits = 0;
        reading = 1'b0;
        if (group == 3 && $urandom % 4 != 0)
            key_vec = key_t'($urandom);                        // Otherwise repeat the last one.
    endtask

    task automatic take_rising_edge();
        if (reading)
        begin
            if (sio_data_oe !== 1'b0)
                stop_with_failure("Controller drove the data line during a key read.");
            rd_bits++;
        end
        else
        begin
            shift_byte = {sio_data_out, shift_byte [7:1]};     // LSB first.
            bit_cnt++;
            if (bit_cnt == 8)
            begin
                wr_bytes.push_back(shift_byte);
                bit_cnt = 0;
                if (group == 3)
                    reading = 1'b1;                            // Key bytes follow.
            end
        end
    endtask

    task automatic close_group();
        int         a;
        logic [2:0] dig;
        if (bit_cnt != 0)
            stop_with_failure("Strobe rose in the middle of a byte.");
        case (group)
            0:
            begin
                check_count("write_group_bytes", 1, wr_bytes.size());
                check_byte("write_cmd", EXP_WRITE, wr_bytes [0]);
            end
            1:
            begin
                check_count("addr_group_bytes", 17, wr_bytes.size());
                check_byte("addr_cmd", EXP_ADDR0, wr_bytes [0]);
                for (a = 0; a < 16; a++)
                begin
                    dig = 3'(a >> 1);
                    if (a % 2 == 0)
                        check_seg($sformatf("frame%0d_digit%0d", frame, dig),
                                  hex_segments(press_count [{dig, 2'b00} +: 4]),
                                  seg_t'(wr_bytes [a + 1]));
                    else
                        check_byte($sformatf("frame%0d_led%0d", frame, dig),
                                   {7'b0, led_exp [dig]}, wr_bytes [a + 1]);
                end
            end
            2:
            begin
                check_count("display_group_bytes", 1, wr_bytes.size());
                check_byte("display_cmd", EXP_DISPLAY, wr_bytes [0]);
            end
            default:
            begin
                check_count("read_group_bytes", 1, wr_bytes.size());
                check_byte("read_cmd", EXP_READ, wr_bytes [0]);
                check_count("read_bits", 32, rd_bits);
                // Every key that went from released to pressed adds one.
                press_count = press_count + count_t'($countones(key_vec & ~key_last));
                key_last    = key_vec;
                led_exp     = key_vec;
                frame++;
            end
        endcase
        group = (group == 3) ? 0 : group + 1;
    endtask

    initial
    begin
        void'($urandom(RNG_SEED));
        sio_data_in = 1'b1;
        shift_byte  = '0;
        bit_cnt     = 0;
        rd_bits     = 0;
        group       = 0;
        frame       = 0;
        gap_clks    = 0;
        reading     = 1'b0;
        started     = 1'b0;
        prev_stb    = 1'b1;
        prev_sclk   = 1'b1;
        key_vec     = '0;
        key_last    = '0;
        press_count = '0;
        led_exp     = '0;
        forever
        begin
            @(negedge clk);
            if (prev_stb && !sio_stb)
                open_group();
            else if (!prev_stb && sio_stb)
            begin
                close_group();
                gap_clks = 0;
            end
            if (!started)
                expect_idle_bus();
            if (sio_stb)
                gap_clks++;
            if (!sio_stb && !prev_sclk && sio_clk)
                take_rising_edge();
            // Driven while a byte goes out, released while keys come in.
            if (!sio_stb && !sio_clk && sio_data_oe !== !reading)
                stop_with_failure("Data enable wrong while the bus clock was low.");
            sio_data_in = (reading && rd_bits < 32) ? read_bit_value(rd_bits) : 1'b1;
            prev_stb    = sio_stb;
            prev_sclk   = sio_clk;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reset, run length and watchdog.

    initial
    begin
        rst = 1'b1;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        while (frame < FRAMES)
            @(posedge clk);
        $display("*** TEST PASSED ***");
        $finish;
    end

    initial
    begin
        #(WATCHDOG);
        stop_with_failure("Timeout: the panel frames did not complete in time.");
    end

endmodule

`default_nettype wire

/* board_specific_top.f */
+incdir+verilog
verilog/board_pkg.sv
verilog/tm_bit_timer.sv
verilog/tm_shift_unit.sv
verilog/tm_frame_builder.sv
verilog/tm1638_board_controller.sv
verilog/lab_top.sv
verilog/board_specific_top.sv
tests/board_chk.sv
tests/tb_board_specific_top.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_board_specific_top
FLIST     = board_specific_top.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FLIST)) $(wildcard verilog/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '\*\*\* TEST FAILED \*\*\*' $(LOG); then echo "Simulation failed."; exit 1; fi
	@if ! grep -q '\*\*\* TEST PASSED \*\*\*' $(LOG); then echo "Simulation ended early."; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
